/* hdl/rv32_pkg.sv */
/* Shared types for the RV32I multicycle core.
   Only LUI, AUIPC, JAL, JALR, branches, the integer ALU group, LW and SW are decoded. */
package rv32_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // Shared by JALR and the full-word load and store
    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [2:0] F3_WORD    = 3'b010;

    // One instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7; reg_idx_t rs2; reg_idx_t rs1;
            logic [2:0] funct3; reg_idx_t rd; logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm; reg_idx_t rs1; logic [2:0] funct3;
            reg_idx_t rd; logic [6:0] opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5; reg_idx_t rs2; reg_idx_t rs1;
            logic [2:0] funct3; logic [4:0] imm_4_0; logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic imm_12; logic [5:0] imm_10_5; reg_idx_t rs2; reg_idx_t rs1;
            logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm; reg_idx_t rd; logic [6:0] opcode;
        } u_fmt;
        struct packed {
            logic imm_20; logic [9:0] imm_10_1; logic imm_11;
            logic [7:0] imm_19_12; reg_idx_t rd; logic [6:0] opcode;
        } j_fmt;
    } instr_u;

    typedef enum logic [3:0] {
        CLS_ALU, CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR,
        CLS_BRANCH, CLS_LOAD, CLS_STORE, CLS_NOP
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_FETCH, ST_DECODE, ST_EXECUTE, ST_ACCESS, ST_WRITEBACK
    } stage_e;

    typedef struct packed {
        op_class_e  op_class;
        alu_op_e    alu_op;
        logic [2:0] funct3;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        word_t      imm;
        logic       use_imm;
    } ctrl_t;

    typedef struct packed {
        word_t result;
        logic  take_branch;
    } exe_t;

    typedef struct packed {
        logic       valid;
        word_t      addr;
        word_t      wdata;
        logic [3:0] wen;
    } mem_req_t;

endpackage

/* hdl/rv32_regfile.sv */
`timescale 1ns/1ps
/* General registers x0 to x31, all cleared by reset.
   Reads are combinational, and writes to x0 are dropped. */
module rv32_regfile
    import rv32_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    input  reg_idx_t i_rd,
    input  logic     i_we,
    input  word_t    i_wdata,
    output word_t    o_rs1_val,
    output word_t    o_rs2_val
);

    word_t regs [2**REG_ADDR_W];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rs1_val = regs[i_rs1];
    assign o_rs2_val = regs[i_rs2];

    a_x0_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        i_we |=> regs[0] == '0)
        else $error("register x0 was overwritten");

endmodule

/* hdl/rv32_decode.sv */
`timescale 1ns/1ps
/* Decodes the captured word in DECODE only; the result holds until the next DECODE.
   Anything outside the supported RV32I subset decodes as a no-op. */
module rv32_decode
    import rv32_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst,
    input  stage_e i_stage,
    input  word_t  i_word,
    output ctrl_t  o_ctrl
);

    instr_u     ins;
    ctrl_t      nxt;
    logic [2:0] f3;
    logic       is_reg;
    logic       is_shift;
    logic       alt;
    logic       alu_legal;
    alu_op_e    alu_pick;

    assign ins      = i_word;
    assign f3       = ins.r_fmt.funct3;
    assign is_reg   = (ins.r_fmt.opcode == OP_REG);
    assign is_shift = (f3 == F3_SLL) || (f3 == F3_SRL_SRA);
    assign alt      = (ins.r_fmt.funct7 == 7'b0100000);

    // Immediate forms carry funct7 only on shifts
    assign alu_legal = (!is_reg && !is_shift) || (ins.r_fmt.funct7 == 7'b0000000) ||
                       (alt && (f3 == F3_SRL_SRA || (is_reg && f3 == F3_ADD_SUB)));

    always_comb begin
        case (f3)
            F3_ADD_SUB: alu_pick = (is_reg && alt) ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_pick = ALU_SLL;
            F3_SLT:     alu_pick = ALU_SLT;
            F3_SLTU:    alu_pick = ALU_SLTU;
            F3_XOR:     alu_pick = ALU_XOR;
            F3_SRL_SRA: alu_pick = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_pick = ALU_OR;
            default:    alu_pick = ALU_AND;
        endcase
    end

    always_comb begin
        nxt          = '0;
        nxt.op_class = CLS_NOP;
        nxt.alu_op   = ALU_ADD;
        nxt.funct3   = f3;
        nxt.rs1      = ins.r_fmt.rs1;
        nxt.rs2      = ins.r_fmt.rs2;
        nxt.rd       = ins.r_fmt.rd;
        nxt.use_imm  = 1'b1;
        nxt.imm      = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
        case (ins.r_fmt.opcode)
            OP_LUI, OP_AUIPC: begin
                nxt.op_class = (ins.r_fmt.opcode == OP_LUI) ? CLS_LUI : CLS_AUIPC;
                nxt.imm      = {ins.u_fmt.imm, 12'b0};
            end
            OP_JAL: begin
                nxt.op_class = CLS_JAL;
                nxt.imm      = {{11{ins.j_fmt.imm_20}}, ins.j_fmt.imm_20, ins.j_fmt.imm_19_12,
                                ins.j_fmt.imm_11, ins.j_fmt.imm_10_1, 1'b0};
            end
            OP_JALR: begin
                if (f3 == F3_JALR) begin
                    nxt.op_class = CLS_JALR;
                end
            end
            OP_BRANCH: begin
                // funct3 010 and 011 are not branches
                if (f3[2:1] != 2'b01) begin
                    nxt.op_class = CLS_BRANCH;
                end
                nxt.imm = {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
                           ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
            end
            OP_IMM, OP_REG: begin
                if (alu_legal) begin
                    nxt.op_class = CLS_ALU;
                    nxt.alu_op   = alu_pick;
                    nxt.use_imm  = !is_reg;
                end
            end
            OP_LOAD: begin
                if (f3 == F3_WORD) begin
                    nxt.op_class = CLS_LOAD;
                end
            end
            OP_STORE: begin
                if (f3 == F3_WORD) begin
                    nxt.op_class = CLS_STORE;
                end
                nxt.imm = {{20{ins.s_fmt.imm_11_5[6]}}, ins.s_fmt.imm_11_5, ins.s_fmt.imm_4_0};
            end
            default: begin
                nxt.op_class = CLS_NOP;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ctrl          <= '0;
            o_ctrl.op_class <= CLS_NOP;
        end else if (i_stage == ST_DECODE) begin
            o_ctrl <= nxt;
        end
    end

endmodule

/* hdl/rv32_execute.sv */
`timescale 1ns/1ps
/* Two EXECUTE cycles: the first latches the operands, the second the results.
   Results are only meaningful once EXECUTE has ended. */
module rv32_execute
    import rv32_pkg::*;
(
    input  logic   i_clk,
    input  stage_e i_stage,
    input  ctrl_t  i_ctrl,
    input  word_t  i_pc,
    input  word_t  i_rs1_val,
    input  word_t  i_rs2_val,
    output exe_t   o_exe
);

    word_t op_a;
    word_t op_b;
    word_t cmp_a;
    word_t cmp_b;
    word_t alu_res;
    logic  take;
    logic  pc_based;

    assign pc_based = (i_ctrl.op_class == CLS_AUIPC) || (i_ctrl.op_class == CLS_JAL) ||
                      (i_ctrl.op_class == CLS_BRANCH);

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (i_ctrl.funct3)
            F3_BEQ:  take = (cmp_a == cmp_b);
            F3_BNE:  take = (cmp_a != cmp_b);
            F3_BLT:  take = ($signed(cmp_a) < $signed(cmp_b));
            F3_BGE:  take = ($signed(cmp_a) >= $signed(cmp_b));
            F3_BLTU: take = (cmp_a < cmp_b);
            F3_BGEU: take = (cmp_a >= cmp_b);
            default: take = 1'b0;
        endcase
    end

    // Both register rows load every EXECUTE cycle, so the result row
    // settles on the second edge from operands taken on the first
    always_ff @(posedge i_clk) begin
        if (i_stage == ST_EXECUTE) begin
            op_a  <= pc_based ? i_pc : i_rs1_val;
            op_b  <= i_ctrl.use_imm ? i_ctrl.imm : i_rs2_val;
            cmp_a <= i_rs1_val;
            cmp_b <= i_rs2_val;
            o_exe.result      <= alu_res;
            o_exe.take_branch <= take;
        end
    end

endmodule

/* hdl/rv32_writeback.sv */
`timescale 1ns/1ps
/* Holds the PC and commits one register write per instruction in WRITEBACK.
   JALR targets have bit 0 cleared; no alignment trap is raised. */
module rv32_writeback
    import rv32_pkg::*;
#(
    parameter word_t PC_START = 32'h8000_0000
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  stage_e   i_stage,
    input  ctrl_t    i_ctrl,
    input  exe_t     i_exe,
    input  word_t    i_load_data,
    output word_t    o_pc,
    output logic     o_we,
    output reg_idx_t o_rd,
    output word_t    o_wdata
);

    word_t pc_plus4;
    word_t next_pc;
    logic  writes_rd;

    assign pc_plus4 = o_pc + 32'd4;

    always_comb begin
        next_pc = pc_plus4;
        case (i_ctrl.op_class)
            CLS_JAL:    next_pc = i_exe.result;
            CLS_JALR:   next_pc = {i_exe.result[XLEN-1:1], 1'b0};
            CLS_BRANCH: next_pc = i_exe.take_branch ? i_exe.result : pc_plus4;
            default:    next_pc = pc_plus4;
        endcase
    end

    always_comb begin
        writes_rd = 1'b1;
        case (i_ctrl.op_class)
            CLS_LUI:           o_wdata = i_ctrl.imm;
            CLS_JAL, CLS_JALR: o_wdata = pc_plus4;
            CLS_LOAD:          o_wdata = i_load_data;
            CLS_ALU, CLS_AUIPC: o_wdata = i_exe.result;
            default: begin
                o_wdata   = i_exe.result;
                writes_rd = 1'b0;
            end
        endcase
    end

    assign o_we = (i_stage == ST_WRITEBACK) && writes_rd;
    assign o_rd = i_ctrl.rd;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc <= PC_START;
        end else if (i_stage == ST_WRITEBACK) begin
            o_pc <= next_pc;
        end
    end

endmodule

/* hdl/rv32_sequencer.sv */
`timescale 1ns/1ps
/* Address, write data and strobes follow the PC or the execute result live.
   Both sources only change outside FETCH and ACCESS, so a waiting request holds. */
module rv32_sequencer
    import rv32_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  op_class_e i_op_class,
    input  word_t     i_addr,
    input  word_t     i_store_data,
    input  word_t     i_pc,
    input  logic      i_mem_ready,
    input  word_t     i_mem_rdata,
    output mem_req_t  o_mem_req,
    output stage_e    o_stage,
    output word_t     o_word
);

    logic req_valid;
    logic exe_second;
    logic is_mem_op;
    logic accepted;

    assign is_mem_op = (i_op_class == CLS_LOAD) || (i_op_class == CLS_STORE);
    assign accepted  = req_valid && i_mem_ready;

    always_comb begin
        o_mem_req.valid = req_valid;
        o_mem_req.addr  = (o_stage == ST_ACCESS) ? i_addr : i_pc;
        o_mem_req.wdata = i_store_data;
        o_mem_req.wen   = (o_stage == ST_ACCESS && i_op_class == CLS_STORE) ? 4'b1111 : 4'b0000;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_stage    <= ST_FETCH;
            req_valid  <= 1'b0;
            exe_second <= 1'b0;
        end else begin
            case (o_stage)
                ST_FETCH: begin
                    // Only right after reset is the fetch request not yet raised
                    if (accepted) begin
                        req_valid <= 1'b0;
                        o_stage   <= ST_DECODE;
                    end else begin
                        req_valid <= 1'b1;
                    end
                end
                ST_DECODE: begin
                    o_stage <= ST_EXECUTE;
                end
                ST_EXECUTE: begin
                    exe_second <= !exe_second;
                    if (exe_second) begin
                        if (is_mem_op) begin
                            o_stage   <= ST_ACCESS;
                            req_valid <= 1'b1;
                        end else begin
                            o_stage <= ST_WRITEBACK;
                        end
                    end
                end
                ST_ACCESS: begin
                    if (accepted) begin
                        req_valid <= 1'b0;
                        o_stage   <= ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK: begin
                    o_stage   <= ST_FETCH;
                    req_valid <= 1'b1;
                end
                default: begin
                    o_stage   <= ST_FETCH;
                    req_valid <= 1'b0;
                end
            endcase
        end
    end

    // Instruction words and load data share one capture register
    always_ff @(posedge i_clk) begin
        if (accepted && o_mem_req.wen == 4'b0000) begin
            o_word <= i_mem_rdata;
        end
    end

    a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        o_mem_req.valid && !i_mem_ready |=> $stable(o_mem_req))
        else $error("memory request changed before it was accepted");

endmodule

/* hdl/rv32_core.sv */
`timescale 1ns/1ps
/* Multicycle RV32I core with one instruction in flight and one valid/ready memory port.
   Unsupported opcodes execute as no-ops. */
module rv32_core
    import rv32_pkg::*;
#(
    parameter word_t PC_START = 32'h8000_0000
) (
    input  logic     i_clk,
    input  logic     i_rst,
    output mem_req_t o_mem_req,
    input  logic     i_mem_ready,
    input  word_t    i_mem_rdata
);

    stage_e   stage;
    word_t    word;
    ctrl_t    ctrl;
    word_t    rs1_val;
    word_t    rs2_val;
    exe_t     exe;
    word_t    pc;
    logic     we;
    reg_idx_t rd;
    word_t    wdata;

    rv32_sequencer u_sequencer (
        .i_clk(i_clk), .i_rst(i_rst), .i_op_class(ctrl.op_class),
        .i_addr(exe.result), .i_store_data(rs2_val), .i_pc(pc),
        .i_mem_ready(i_mem_ready), .i_mem_rdata(i_mem_rdata),
        .o_mem_req(o_mem_req), .o_stage(stage), .o_word(word)
    );

    rv32_decode u_decode (
        .i_clk(i_clk), .i_rst(i_rst), .i_stage(stage), .i_word(word), .o_ctrl(ctrl)
    );

    rv32_regfile u_regfile (
        .i_clk(i_clk), .i_rst(i_rst), .i_rs1(ctrl.rs1), .i_rs2(ctrl.rs2),
        .i_rd(rd), .i_we(we), .i_wdata(wdata),
        .o_rs1_val(rs1_val), .o_rs2_val(rs2_val)
    );

    rv32_execute u_execute (
        .i_clk(i_clk), .i_stage(stage), .i_ctrl(ctrl), .i_pc(pc),
        .i_rs1_val(rs1_val), .i_rs2_val(rs2_val), .o_exe(exe)
    );

    rv32_writeback #(.PC_START(PC_START)) u_writeback (
        .i_clk(i_clk), .i_rst(i_rst), .i_stage(stage), .i_ctrl(ctrl), .i_exe(exe),
        .i_load_data(word), .o_pc(pc), .o_we(we), .o_rd(rd), .o_wdata(wdata)
    );

endmodule

/* bench/rv32_tb_clock.sv */
`timescale 1ns/1ps
/* Free-running testbench clock with a synchronous, active-high reset pulse.
   The clock starts low, so the first rising edge is at half a period. */
module rv32_tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

/* bench/rv32_core_tb.sv */
`timescale 1ns/1ps
/* Runs the program in bench/rv32_core_patterns.hex on a 256-word memory based at PC_START,
   with 1 to 4 cycles until ready on every request. Each accepted SW is checked in order
   against the expected address/value list that follows the program in the same file. */
module rv32_core_tb
    import rv32_pkg::*;
();

    localparam word_t PC_START  = 32'h8000_0000;
    localparam int    MEM_WORDS = 256;
    // Program words lie below this index, the store count and pairs from it upward
    localparam int    EXP_BASE  = 'h60;
    localparam int    WATCHDOG_CYCLES = 40 * EXP_BASE * 4;

    logic     clk;
    logic     rst;
    mem_req_t mem_req;
    logic     mem_ready;
    word_t    mem_rdata;

    word_t    mem [MEM_WORDS];
    word_t    exp_addr [$];
    word_t    exp_data [$];
    integer   seed;
    int       wait_left;
    int       num_tests;
    int       checked;
    int       pass_count;
    int       fail_count;

    rv32_tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clock (.o_clk(clk), .o_rst(rst));

    rv32_core #(.PC_START(PC_START)) uut (
        .i_clk(clk), .i_rst(rst), .o_mem_req(mem_req),
        .i_mem_ready(mem_ready), .i_mem_rdata(mem_rdata)
    );

    function automatic logic in_memory(input word_t addr);
        word_t offset;
        offset = addr - PC_START;
        return offset < MEM_WORDS * 4;
    endfunction

    function automatic int mem_index(input word_t addr);
        return int'((addr - PC_START) >> 2);
    endfunction

    task automatic compare_word(input string name, input word_t expected, input word_t actual,
                                output logic ok);
        ok = (expected === actual);
        if (!ok) begin
            $display("error: %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_store(input word_t addr, input word_t data, input logic [3:0] wen);
        string name;
        logic  addr_ok;
        logic  data_ok;
        logic  wen_ok;
        if (checked >= num_tests) begin
            $display("The core stored %08h to %08h after the last expected store", data, addr);
            fail_count++;
        end else begin
            name = $sformatf("test %0d", checked);
            compare_word({name, " address"}, exp_addr[checked], addr, addr_ok);
            compare_word({name, " data"}, exp_data[checked], data, data_ok);
            // A full-word store enables all four byte lanes
            compare_word({name, " strobes"}, 32'h0000_000F, {28'b0, wen}, wen_ok);
            if (addr_ok && data_ok && wen_ok) begin
                $display("%s passed", name);
                pass_count++;
            end else begin
                fail_count++;
            end
            checked++;
        end
    endtask

    task automatic load_patterns();
        // Unloaded words read back as the inverted byte address
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = ~(PC_START + word_t'(4 * i));
        end
        $readmemh("bench/rv32_core_patterns.hex", mem);
        num_tests = mem[EXP_BASE];
        if (num_tests <= 0 || EXP_BASE + 1 + 2 * num_tests > MEM_WORDS) begin
            $display("The pattern file holds no usable count of expected stores");
            num_tests = 0;
        end
        for (int i = 0; i < num_tests; i++) begin
            exp_addr.push_back(mem[EXP_BASE + 1 + 2 * i]);
            exp_data.push_back(mem[EXP_BASE + 2 + 2 * i]);
        end
    endtask

    // Memory model: ready rises after the random wait, with read data already in place
    always @(posedge clk) begin
        if (rst) begin
            mem_ready <= 1'b0;
            wait_left <= $random(seed) & 3;
        end else if (mem_req.valid && mem_ready) begin
            mem_ready <= 1'b0;
            wait_left <= $random(seed) & 3;
            if (mem_req.wen != 4'b0000) begin
                if (in_memory(mem_req.addr)) begin
                    mem[mem_index(mem_req.addr)] <= mem_req.wdata;
                end
                check_store(mem_req.addr, mem_req.wdata, mem_req.wen);
            end
        end else if (mem_req.valid) begin
            if (wait_left > 0) begin
                wait_left <= wait_left - 1;
            end else begin
                mem_ready <= 1'b1;
                if (in_memory(mem_req.addr)) begin
                    mem_rdata <= mem[mem_index(mem_req.addr)];
                end else begin
                    $display("The core accessed %08h, outside the memory model", mem_req.addr);
                    fail_count++;
                    mem_rdata <= '0;
                end
            end
        end
    end

    initial begin
        seed       = 32'h8564;
        mem_ready  = 1'b0;
        mem_rdata  = '0;
        wait_left  = 0;
        checked    = 0;
        pass_count = 0;
        fail_count = 0;
        load_patterns();
        wait (checked >= num_tests);
        @(posedge clk);
        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && num_tests > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the core stopped making stores after %0d of %0d expected stores",
                 checked, num_tests);
        $display("Verification failed");
        $finish;
    end

endmodule

/* rv32_multicycle.f */
hdl/rv32_pkg.sv
hdl/rv32_regfile.sv
hdl/rv32_decode.sv
hdl/rv32_execute.sv
hdl/rv32_writeback.sv
hdl/rv32_sequencer.sv
hdl/rv32_core.sv
bench/rv32_tb_clock.sv
bench/rv32_core_tb.sv

/* bench/rv32_core_patterns.hex */
// Program words from PC_START, two or three per line in execution order.
// At @60: the count of expected stores, then two stores per line as address value address value.
@00
800000B7 30008093
FFF00113 00500193
// Immediate group: addi slti sltiu xori ori andi slli srli srai, each followed by SW
00710213 0040A023
00112293 0050A223
00113313 0060A423
FFF1C393 0070A623
7F01E413 0080A823
0F017493 0090AA23
01E19513 00A0AC23
01C15593 00B0AE23
4080D613 02C0A023
// Register group: add sub slt sltu sra and
002186B3 02D0A223
40118733 02E0A423
003127B3 02F0A623
00313833 0300A823
4030D8B3 0310AA23
0020F933 0320AC23
// LUI and AUIPC, then JAL and JALR that each jump over one SW
123459B7 0330AE23
00001A17 0540A023
00800AEF 0420A223 0550A223
011A8B67 0420A423 0560A423
// Branch, SW of x3 on the not-taken path only, SW of x13 on both paths
00318463 0430A623 04D0A823
00310463 0430AA23 04D0AC23
00311463 0430AE23 06D0A023
00319463 0630A223 06D0A423
00314463 0630A623 06D0A823
0021C463 0630AA23 06D0AC23
0021D463 0630AE23 08D0A023
00315463 0830A223 08D0A423
0021E463 0830A623 08D0A823
00316463 0830AA23 08D0AC23
00317463 0830AE23 0AD0A023
0021F463 0A30A223 0AD0A423
// LW of an earlier store, a discarded write to x0, and LW of the stored x0
0200AC03 0B80A623
00718013 0A00A823
0B00AC83 0B90AA23
0000006F
@60
00000028
80000300 00000006 80000304 00000001
80000308 00000000 8000030C FFFFFFFA
80000310 000007F5 80000314 000000F0
80000318 40000000 8000031C 0000000F
80000320 FF800003 80000324 00000004
80000328 7FFFFD05 8000032C 00000001
80000330 00000000 80000334 FC000018
80000338 80000300 8000033C 12345000
80000340 80001090 80000344 8000009C
80000348 800000A8 80000350 00000004
80000354 00000005 80000358 00000004
80000360 00000004 80000364 00000005
80000368 00000004 80000370 00000004
80000374 00000005 80000378 00000004
80000380 00000004 80000384 00000005
80000388 00000004 80000390 00000004
80000394 00000005 80000398 00000004
800003A0 00000004 800003A4 00000005
800003A8 00000004 800003AC FF800003
800003B0 00000000 800003B4 00000000
